// ==== mem_arb_top.f ====
+incdir+rtl
rtl/mem_arb_pkg.sv
rtl/lru_arb.sv
rtl/shared_mem_port.sv
rtl/apb_arb_csr.sv
rtl/mem_arb_top.sv
verif/tb_clk_gen.sv
verif/mem_arb_checker.sv
verif/mem_arb_tb.sv

// ==== Bender.yml ====
package:
  name: mem_arb_top

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_arb_pkg.sv
      - rtl/lru_arb.sv
      - rtl/shared_mem_port.sv
      - rtl/apb_arb_csr.sv
      - rtl/mem_arb_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_clk_gen.sv
      - verif/mem_arb_checker.sv
      - verif/mem_arb_tb.sv

// ==== verif/mem_arb_testdata.txt ====
# All values hex. C req then op addr wdata for clients 0..2, requests held until granted
# H req cycles then op addr wdata x3, requests held high. W/R paddr data pslverr
# Rotation from reset, each client writes its own word
H 7 9 1 1 a0a0a0a0 1 2 b1b1b1b1 1 3 c2c2c2c2
R 4 00000003 0
R 8 00000003 0
R c 00000003 0
# Write by one client, read back by another
C 1 1 5 12345678 0 0 00000000 0 0 00000000
C 2 0 0 00000000 0 5 00000000 0 0 00000000
C 3 1 6 cafef00d 0 6 00000000 0 0 00000000
# Mixed request patterns
C 7 0 1 00000000 0 2 00000000 1 7 77777777
C 5 0 3 00000000 0 0 00000000 0 1 00000000
C 6 0 0 00000000 0 7 00000000 0 2 00000000
H 3 4 1 8 11111111 1 9 22222222 0 0 00000000
R 4 00000009 0
R 8 00000009 0
R c 00000006 0
# Client 0 masked off, then enabled again
W 0 00000006 0
R 0 00000006 0
H 7 6 1 a 0a0a0a0a 1 b bbbbbbbb 1 c cccccccc
W 0 00000007 0
H 7 3 1 a 0a0a0a0a 1 b bbbbbbbb 1 c cccccccc
# Counters and bus errors
R 4 0000000a 0
R 8 0000000d 0
R c 0000000a 0
R 2 00000000 1
W 4 00000055 1
W 1 00000000 1
R 0 00000007 0
R 4 0000000a 0
C 4 0 0 00000000 0 0 00000000 0 c 00000000

// ==== verif/mem_arb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module mem_arb_tb import mem_arb_pkg::*; ();

	localparam int N = `MEM_ARB_NUM_CLIENTS;
	localparam int TIMEOUT = 50;

	logic                              clk;
	logic                              rst_n;
	logic [N-1:0]                      req;
	mem_op_e [N-1:0]                   op;
	logic [N-1:0][`MEM_ARB_ADDR_W-1:0] addr;
	logic [N-1:0][`MEM_ARB_DATA_W-1:0] wdata;
	logic [N-1:0]                      grt;
	logic [`MEM_ARB_DATA_W-1:0]        rdata;
	logic                              rvalid;
	logic                              psel;
	logic                              penable;
	logic                              pwrite;
	logic [`MEM_ARB_APB_AW-1:0]        paddr;
	logic [`MEM_ARB_DATA_W-1:0]        pwdata;
	logic [`MEM_ARB_DATA_W-1:0]        prdata;
	logic                              pready;
	logic                              pslverr;
	int                                tb_errors;
	int                                chk_errors;

	tb_clk_gen tb_clk_gen_inst (.clk(clk), .rst_n(rst_n));
	mem_arb_top mem_arb_top_inst (.*);
	mem_arb_checker mem_arb_checker_inst (.*, .errors(chk_errors));

	// Inputs always change 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_client_fields(input int fd, output bit ok);
		logic                       f_op [N];
		logic [`MEM_ARB_ADDR_W-1:0] f_addr [N];
		logic [`MEM_ARB_DATA_W-1:0] f_data [N];
		int                         n;
		n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h", f_op[0], f_addr[0], f_data[0],
			f_op[1], f_addr[1], f_data[1], f_op[2], f_addr[2], f_data[2]);
		ok = (n == 9);
		for (int c = 0; c < N; c++) begin
			op[c] = mem_op_e'(f_op[c]);
			addr[c] = f_addr[c];
			wdata[c] = f_data[c];
		end
	endtask

	// Each client keeps its request up until it is granted, reads also wait for rvalid
	task automatic run_requests(input logic [N-1:0] r);
		logic [N-1:0] pend;
		logic [N-1:0] won;
		logic         rd_due;
		int           waited;
		pend = r;
		rd_due = 1'b0;
		waited = 0;
		req = pend;
		while ((pend != '0 || rd_due) && waited < TIMEOUT) begin
			@(negedge clk);
			if (rvalid)
				rd_due = 1'b0;
			won = grt & pend;
			for (int c = 0; c < N; c++) begin
				if (won[c] && op[c] == MEM_READ)
					rd_due = 1'b1;
			end
			step_cycle();
			pend = pend & ~won;
			req = pend;
			waited++;
		end
		for (int c = 0; c < N; c++) begin
			if (pend[c]) begin
				$display("Client %0d was never granted", c);
				tb_errors++;
			end
		end
		if (rd_due) begin
			$display("Read data never came back with rvalid");
			tb_errors++;
		end
		req = '0;
	endtask

	task automatic run_apb(input logic wr, input logic [`MEM_ARB_APB_AW-1:0] a,
		input logic [`MEM_ARB_DATA_W-1:0] value, input logic exp_err);
		logic [`MEM_ARB_DATA_W-1:0] got_rd;
		logic                       got_err;
		logic                       done;
		int                         waited;
		psel = 1'b1;
		pwrite = wr;
		paddr = a;
		pwdata = wr ? value : '0;
		step_cycle();
		penable = 1'b1;
		done = 1'b0;
		waited = 0;
		while (!done && waited < TIMEOUT) begin
			@(negedge clk);
			if (pready) begin
				done = 1'b1;
				got_rd = prdata;
				got_err = pslverr;
			end
			step_cycle();
			waited++;
		end
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		if (!done) begin
			$display("APB access to offset 0x%h never completed", a);
			tb_errors++;
		end else begin
			if (got_err !== exp_err) begin
				$display("Error at %0t ns: pslverr at offset 0x%h is %b, expected %b",
					$time, a, got_err, exp_err);
				tb_errors++;
			end
			if (!wr && !exp_err && got_rd !== value) begin
				$display("Error at %0t ns: prdata at offset 0x%h is 0x%h, expected 0x%h",
					$time, a, got_rd, value);
				tb_errors++;
			end
		end
	endtask

	initial begin
		int                         fd;
		int                         n;
		int                         waited;
		int unsigned                seed;
		logic [7:0]                 cmd;
		logic [8*200-1:0]           line;
		logic [N-1:0]               f_req;
		int                         f_cyc;
		logic [`MEM_ARB_APB_AW-1:0] f_addr;
		logic [`MEM_ARB_DATA_W-1:0] f_val;
		logic                       f_err;
		bit                         ok;
		bit                         stop;
		req = '0;
		for (int c = 0; c < N; c++)
			op[c] = MEM_READ;
		addr = '0;
		wdata = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		tb_errors = 0;
		seed = 32'h2507fa0e;
		n = $urandom(seed);

		waited = 0;
		while (rst_n !== 1'b1 && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		step_cycle();
		fd = $fopen("verif/mem_arb_testdata.txt", "r");
		if (rst_n !== 1'b1) begin
			$display("Reset was never released");
			tb_errors++;
		end else if (fd == 0) begin
			$display("Could not open verif/mem_arb_testdata.txt");
			tb_errors++;
		end else begin
			stop = 1'b0;
			while (!stop) begin
				ok = 1'b1;
				n = $fscanf(fd, " %c", cmd);
				if (n != 1) begin
					stop = 1'b1;
				end else begin
					case (cmd)
						"#": n = $fgets(line, fd);
						"C": begin
							n = $fscanf(fd, " %h", f_req);
							load_client_fields(fd, ok);
							ok = ok && (n == 1);
							if (ok)
								run_requests(f_req);
						end
						"H": begin
							n = $fscanf(fd, " %h %h", f_req, f_cyc);
							load_client_fields(fd, ok);
							ok = ok && (n == 2);
							if (ok) begin
								req = f_req;
								repeat (f_cyc) step_cycle();
								req = '0;
							end
						end
						"W", "R": begin
							n = $fscanf(fd, " %h %h %h", f_addr, f_val, f_err);
							ok = (n == 3);
							if (ok)
								run_apb(cmd == "W", f_addr, f_val, f_err);
						end
						default: ok = 1'b0;
					endcase
					if (!ok) begin
						$display("Test data line starting with %c could not be parsed", cmd);
						tb_errors++;
						stop = 1'b1;
					end
					repeat ($urandom_range(3, 0)) step_cycle();
				end
			end
			$fclose(fd);
		end

		// Let the checker see the last read return
		repeat (3) step_cycle();
		$display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/mem_arb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module mem_arb_checker import mem_arb_pkg::*; (
	input  wire                                                  clk,
	input  wire                                                  rst_n,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0]                      req,
	input  wire  mem_op_e [`MEM_ARB_NUM_CLIENTS-1:0]             op,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0][`MEM_ARB_ADDR_W-1:0] addr,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0][`MEM_ARB_DATA_W-1:0] wdata,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0]                      grt,
	input  wire  [`MEM_ARB_DATA_W-1:0]                           rdata,
	input  wire                                                  rvalid,
	input  wire                                                  psel,
	input  wire                                                  penable,
	input  wire                                                  pwrite,
	input  wire  [`MEM_ARB_APB_AW-1:0]                           paddr,
	input  wire  [`MEM_ARB_DATA_W-1:0]                           pwdata,
	input  wire  [`MEM_ARB_DATA_W-1:0]                           prdata,
	input  wire                                                  pready,
	input  wire                                                  pslverr,
	output int                                                   errors
);

	localparam int N = `MEM_ARB_NUM_CLIENTS;

	// Model state, stepped at the falling edge for the rising edge that follows
	int                         pri [N];
	logic [N-1:0]               en;
	logic [15:0]                cnt [N];
	logic [`MEM_ARB_DATA_W-1:0] mem_img [`MEM_ARB_MEM_DEPTH];
	logic                       rd_due;
	logic [`MEM_ARB_DATA_W-1:0] rd_exp;

	task automatic report_mismatch(input string what, input logic [`MEM_ARB_DATA_W-1:0] got,
		input logic [`MEM_ARB_DATA_W-1:0] exp);
		$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		errors++;
	endtask

	initial errors = 0;

	always @(negedge clk) begin : model_step
		int                         win;
		int                         win_pri;
		logic [N-1:0]               exp_grt;
		logic [`MEM_ARB_DATA_W-1:0] exp_rd;
		logic                       access;
		logic                       mapped;
		logic                       exp_err;
		if (!rst_n) begin
			for (int c = 0; c < N; c++) begin
				pri[c] = c;
				cnt[c] = '0;
			end
			for (int a = 0; a < `MEM_ARB_MEM_DEPTH; a++)
				mem_img[a] = '0;
			en = '1;
			rd_due = 1'b0;
		end else begin
			// Read data belongs to the grant of the last rising edge
			if (rvalid !== rd_due)
				report_mismatch("rvalid", rvalid, rd_due);
			else if (rd_due && rdata !== rd_exp)
				report_mismatch("rdata", rdata, rd_exp);

			// The enabled requester with the smallest priority value wins
			win = -1;
			for (int c = 0; c < N; c++) begin
				if (req[c] && en[c] && (win < 0 || pri[c] < pri[win]))
					win = c;
			end
			exp_grt = '0;
			if (win >= 0)
				exp_grt[win] = 1'b1;
			if (grt !== exp_grt)
				report_mismatch("grt", grt, exp_grt);

			access = psel && penable;
			mapped = (paddr == CSR_MASK) || (paddr == CSR_CNT0) ||
				(paddr == CSR_CNT1) || (paddr == CSR_CNT2);
			exp_err = access && (!mapped || (pwrite && paddr != CSR_MASK));
			exp_rd = '0;
			case (csr_addr_e'(paddr))
				CSR_MASK: exp_rd[N-1:0] = en;
				CSR_CNT0: exp_rd[15:0] = cnt[0];
				CSR_CNT1: exp_rd[15:0] = cnt[1];
				CSR_CNT2: exp_rd[15:0] = cnt[2];
				default: exp_rd = '0;
			endcase
			if (pready !== access)
				report_mismatch("pready", pready, access);
			if (pslverr !== exp_err)
				report_mismatch("pslverr", pslverr, exp_err);
			if (access && !pwrite && mapped && prdata !== exp_rd)
				report_mismatch("prdata", prdata, exp_rd);

			rd_due = 1'b0;
			if (win >= 0) begin
				win_pri = pri[win];
				cnt[win] = cnt[win] + 1'b1;
				if (op[win] == MEM_WRITE) begin
					mem_img[addr[win]] = wdata[win];
				end else begin
					rd_due = 1'b1;
					rd_exp = mem_img[addr[win]];
				end
				// Winner drops to the bottom and the clients below it move up one
				for (int c = 0; c < N; c++) begin
					if (c == win)
						pri[c] = N - 1;
					else if (pri[c] > win_pri)
						pri[c] = pri[c] - 1;
				end
			end
			if (access && pwrite && paddr == CSR_MASK)
				en = pwdata[N-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset is held over the first five rising edges
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== rtl/mem_arb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module mem_arb_top import mem_arb_pkg::*; (
	input  wire                                                  clk,
	input  wire                                                  rst_n,

	// Client request side
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0]                      req,
	input  wire  mem_op_e [`MEM_ARB_NUM_CLIENTS-1:0]             op,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0][`MEM_ARB_ADDR_W-1:0] addr,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0][`MEM_ARB_DATA_W-1:0] wdata,
	output logic [`MEM_ARB_NUM_CLIENTS-1:0]                      grt,
	output logic [`MEM_ARB_DATA_W-1:0]                           rdata,
	output logic                                                 rvalid,

	// APB control port
	input  wire                                                  psel,
	input  wire                                                  penable,
	input  wire                                                  pwrite,
	input  wire  [`MEM_ARB_APB_AW-1:0]                           paddr,
	input  wire  [`MEM_ARB_DATA_W-1:0]                           pwdata,
	output logic [`MEM_ARB_DATA_W-1:0]                           prdata,
	output logic                                                 pready,
	output logic                                                 pslverr
);

	logic [`MEM_ARB_NUM_CLIENTS-1:0] client_en;
	logic [`MEM_ARB_NUM_CLIENTS-1:0] req_masked;

	// Disabled clients are hidden from the arbiter and keep their rank
	assign req_masked = req & client_en;

	lru_arb lru_arb_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req_masked),
		.grt   (grt)
	);

	shared_mem_port shared_mem_port_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.grt    (grt),
		.op     (op),
		.addr   (addr),
		.wdata  (wdata),
		.rdata  (rdata),
		.rvalid (rvalid)
	);

	apb_arb_csr apb_arb_csr_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.grt       (grt),
		.client_en (client_en)
	);

endmodule

`default_nettype wire

// ==== rtl/apb_arb_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module apb_arb_csr import mem_arb_pkg::*; (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             psel,
	input  wire                             penable,
	input  wire                             pwrite,
	input  wire  [`MEM_ARB_APB_AW-1:0]      paddr,
	input  wire  [`MEM_ARB_DATA_W-1:0]      pwdata,
	output logic [`MEM_ARB_DATA_W-1:0]      prdata,
	output logic                            pready,
	output logic                            pslverr,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0] grt,
	output logic [`MEM_ARB_NUM_CLIENTS-1:0] client_en
);

	localparam int CNT_W = 16;

	csr_addr_e        csr_addr;
	logic             access;
	logic             addr_hit;
	logic             cnt_hit;
	logic             mask_wr;
	logic [CNT_W-1:0] grant_cnt [`MEM_ARB_NUM_CLIENTS];

	// No wait states, every access phase completes at once
	assign access = psel & penable;
	assign csr_addr = csr_addr_e'(paddr);

	// Offset decode and read mux
	always_comb begin
		addr_hit = 1'b1;
		cnt_hit = 1'b0;
		prdata = '0;
		case (csr_addr)
			CSR_MASK: begin
				prdata[`MEM_ARB_NUM_CLIENTS-1:0] = client_en;
			end
			CSR_CNT0: begin
				cnt_hit = 1'b1;
				prdata[CNT_W-1:0] = grant_cnt[0];
			end
			CSR_CNT1: begin
				cnt_hit = 1'b1;
				prdata[CNT_W-1:0] = grant_cnt[1];
			end
			CSR_CNT2: begin
				cnt_hit = 1'b1;
				prdata[CNT_W-1:0] = grant_cnt[2];
			end
			default: begin
				addr_hit = 1'b0;
			end
		endcase
	end

	assign pready = access;
	// Counters are read only
	assign pslverr = access & (~addr_hit | (pwrite & cnt_hit));
	assign mask_wr = access & pwrite & (csr_addr == CSR_MASK);

	// All clients start enabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			client_en <= '1;
		else if (mask_wr)
			client_en <= pwdata[`MEM_ARB_NUM_CLIENTS-1:0];
	end

	// Counters wrap silently at 16 bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < `MEM_ARB_NUM_CLIENTS; c++)
				grant_cnt[c] <= '0;
		end else begin
			for (int c = 0; c < `MEM_ARB_NUM_CLIENTS; c++) begin
				if (grt[c])
					grant_cnt[c] <= grant_cnt[c] + 1'b1;
			end
		end
	end

	a_penable_in_psel: assert property (
		@(posedge clk) disable iff (!rst_n)
		penable |-> psel
	) else $error("apb_arb_csr: penable without psel");

endmodule

`default_nettype wire

// ==== rtl/shared_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module shared_mem_port import mem_arb_pkg::*; (
	input  wire                                                  clk,
	input  wire                                                  rst_n,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0]                      grt,
	input  wire  mem_op_e [`MEM_ARB_NUM_CLIENTS-1:0]             op,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0][`MEM_ARB_ADDR_W-1:0] addr,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0][`MEM_ARB_DATA_W-1:0] wdata,
	output logic [`MEM_ARB_DATA_W-1:0]                           rdata,
	output logic                                                 rvalid
);

	// Fields of the client that owns the memory in this cycle
	logic                       acc_en;
	mem_op_e                    acc_op;
	logic [`MEM_ARB_ADDR_W-1:0] acc_addr;
	logic [`MEM_ARB_DATA_W-1:0] acc_wdata;

	logic                       wr_en;
	logic                       rd_en;

	logic [`MEM_ARB_DATA_W-1:0] mem [`MEM_ARB_MEM_DEPTH];

	// The grant is one-hot, so an OR of the selected fields is enough
	always_comb begin
		acc_en = 1'b0;
		acc_op = MEM_READ;
		acc_addr = '0;
		acc_wdata = '0;
		for (int c = 0; c < `MEM_ARB_NUM_CLIENTS; c++) begin
			if (grt[c]) begin
				acc_en = 1'b1;
				acc_op = op[c];
				acc_addr = addr[c];
				acc_wdata = wdata[c];
			end
		end
	end

	assign wr_en = acc_en && (acc_op == MEM_WRITE);
	assign rd_en = acc_en && (acc_op == MEM_READ);

	// Single port array, one access per edge at most
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[acc_addr] <= acc_wdata;
	end

	// Read data is held until the next granted read
	always_ff @(posedge clk) begin
		if (rd_en)
			rdata <= mem[acc_addr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rvalid <= 1'b0;
		else
			rvalid <= rd_en;
	end

	// Checked against the raw client opcodes, so a bad field select shows up too
	a_rvalid_after_read: assert property (
		@(posedge clk) disable iff (!rst_n)
		rvalid |-> $past(|(grt & ~op))
	) else $error("shared_mem_port: rvalid without a granted read");

endmodule

`default_nettype wire

// ==== rtl/lru_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_config.svh"

module lru_arb import mem_arb_pkg::*; (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire  [`MEM_ARB_NUM_CLIENTS-1:0] req,
	output logic [`MEM_ARB_NUM_CLIENTS-1:0] grt
);

	localparam client_id_t LOWEST_PRI = client_id_t'(`MEM_ARB_NUM_CLIENTS - 1);

	// Priority value held by each client
	client_id_t pri [`MEM_ARB_NUM_CLIENTS];

	// Which client currently sits at each priority rank
	client_id_t rank_id [`MEM_ARB_NUM_CLIENTS];

	// Rank of the client granted in this cycle
	client_id_t win_pri;

	// Invert the priority table so the grant can walk ranks in order
	always_comb begin
		for (int r = 0; r < `MEM_ARB_NUM_CLIENTS; r++) begin
			if (pri[0] == client_id_t'(r))
				rank_id[r] = client_id_t'(0);
			else if (pri[1] == client_id_t'(r))
				rank_id[r] = client_id_t'(1);
			else
				rank_id[r] = client_id_t'(2);
		end
	end

	// The best ranked requester wins and the grant is visible in the request cycle
	always_comb begin
		grt = '0;
		win_pri = LOWEST_PRI;
		if (req[rank_id[0]]) begin
			grt[rank_id[0]] = 1'b1;
			win_pri = client_id_t'(0);
		end else if (req[rank_id[1]]) begin
			grt[rank_id[1]] = 1'b1;
			win_pri = client_id_t'(1);
		end else if (req[rank_id[2]]) begin
			grt[rank_id[2]] = 1'b1;
			win_pri = client_id_t'(2);
		end
	end

	// Winner drops to the bottom and everyone that was below it moves up one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < `MEM_ARB_NUM_CLIENTS; c++)
				pri[c] <= client_id_t'(c);
		end else if (|grt) begin
			for (int c = 0; c < `MEM_ARB_NUM_CLIENTS; c++) begin
				if (grt[c])
					pri[c] <= LOWEST_PRI;
				else if (pri[c] > win_pri)
					pri[c] <= pri[c] - 1'b1;
			end
		end
	end

	// Any live request is answered by exactly one grant
	a_grt_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		(req != '0) |-> $onehot(grt)
	) else $error("lru_arb: live request without exactly one grant");

	// The grant answers a live request and no other requester outranks it
	a_grt_in_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		((grt & ~req) == '0) &&
		(!req[0] || grt[0] || pri[0] > win_pri) &&
		(!req[1] || grt[1] || pri[1] > win_pri) &&
		(!req[2] || grt[2] || pri[2] > win_pri)
	) else $error("lru_arb: grant does not go to the best ranked request");

	// Every rank is held by exactly one client and out of range values drop out of the shift
	a_pri_perm: assert property (
		@(posedge clk) disable iff (!rst_n)
		((3'b001 << pri[0]) | (3'b001 << pri[1]) | (3'b001 << pri[2])) == 3'b111
	) else $error("lru_arb: priority table is not a permutation");

endmodule

`default_nettype wire

// ==== rtl/mem_arb_pkg.sv ====
`default_nettype none

`include "mem_arb_config.svh"

package mem_arb_pkg;

	// Client index, also used as a priority value where 0 is served first
	typedef logic [$clog2(`MEM_ARB_NUM_CLIENTS)-1:0] client_id_t;

	// Memory access opcode carried with each client request
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

	// APB register offsets of the CSR block
	// Anything not listed here answers with pslverr
	typedef enum logic [`MEM_ARB_APB_AW-1:0] {
		CSR_MASK = 4'h0,
		CSR_CNT0 = 4'h4,
		CSR_CNT1 = 4'h8,
		CSR_CNT2 = 4'hC
	} csr_addr_e;

endpackage

`default_nettype wire

// ==== rtl/mem_arb_config.svh ====
`ifndef MEM_ARB_CONFIG_SVH
`define MEM_ARB_CONFIG_SVH

// Number of clients sharing the memory
// The LRU priority logic is written for exactly three
`define MEM_ARB_NUM_CLIENTS 3

// Word address width of the shared memory
`define MEM_ARB_ADDR_W 4

// Width of a memory word and of the APB data bus
`define MEM_ARB_DATA_W 32

// Number of words in the shared memory
`define MEM_ARB_MEM_DEPTH (1 << `MEM_ARB_ADDR_W)

// Byte offset width of the CSR block on APB
`define MEM_ARB_APB_AW 4

`endif
